/* Bender.yml */
package:
  name: funct_generator

sources:
  # RTL
  - files:
      - hdl/funct_gen_pkg.sv
      - hdl/gen_fsm.sv
      - hdl/phase_counter.sv
      - hdl/wave_lut.sv
      - hdl/amp_scaler.sv
      - hdl/funct_generator.sv

  # Testbench
  - target: test
    files:
      - testbench/tb_funct_generator.sv

/* files.f */
hdl/funct_gen_pkg.sv
hdl/gen_fsm.sv
hdl/phase_counter.sv
hdl/wave_lut.sv
hdl/amp_scaler.sv
hdl/funct_generator.sv
testbench/tb_funct_generator.sv

/* hdl/amp_scaler.sv */
`timescale 1ns/1ns

module amp_scaler
	import funct_gen_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         load_amp_i,
	input  amp_t         amp_i,
	input  wave_sample_t sample_i,
	output sample_t      data_o,
	output logic         wr_en_o
);

	sample_t                       amp_q;
	logic signed [PROD_WIDTH-1:0]  product;
	sample_t                       data_q;
	logic                          wr_en_q;

	// The amplitude input is a whole number.
	// It lands in the integer bits of the Q4.12 register.
	// Out of reset the gain is one.
	always_ff @(posedge clk) begin
		if (rst) begin
			amp_q <= sample_t'(FULL_SCALE);
		end else if (load_amp_i) begin
			amp_q <= {amp_i, {FRAC_BITS{1'b0}}};
		end
	end

	// Full signed product of two Q4.12 numbers, which is Q8.24.
	// The gain in use is whatever the register holds in the cycle of the multiply.
	assign product = sample_i.sample * amp_q;

	// Dropping the low fraction bits returns to Q4.12.
	// The high bits are discarded, so an overflow wraps.
	// The output keeps its last value between valid samples.
	always_ff @(posedge clk) begin
		if (rst) begin
			data_q  <= '0;
			wr_en_q <= 1'b0;
		end else begin
			wr_en_q <= sample_i.valid;
			if (sample_i.valid) begin
				data_q <= product[FRAC_BITS +: DATA_WIDTH];
			end
		end
	end

	assign data_o  = data_q;
	assign wr_en_o = wr_en_q;

endmodule

/* hdl/funct_gen_pkg.sv */
package funct_gen_pkg;

	// Sample width and its split into integer and fraction bits (Q4.12).
	localparam int DATA_WIDTH = 16;
	localparam int INT_BITS   = 4;
	localparam int FRAC_BITS  = DATA_WIDTH - INT_BITS;

	// The phase address walks one full period of the table.
	localparam int LUT_ADDR       = 5;
	localparam int LUT_DEPTH      = 2 ** LUT_ADDR;
	localparam int QUARTER_OFFSET = LUT_DEPTH / 4;

	// Plus one in Q4.12, and the rise of the triangle per folded step.
	localparam int FULL_SCALE = 1 << FRAC_BITS;
	localparam int TRI_STEP   = 512;

	// A signed sample times a signed amplitude needs twice the sample width.
	localparam int PROD_WIDTH = 2 * DATA_WIDTH;

	// Signed Q4.12 sine samples, one hex word per line.
	localparam string SINE_FILE = "sine_table.hex";

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		CONFI = 2'd1,
		GEN   = 2'd2
	} state_t;

	// The codes follow the values of sel_i.
	typedef enum logic [1:0] {
		SINE     = 2'd0,
		COSINE   = 2'd1,
		TRIANGLE = 2'd2,
		SQUARE   = 2'd3
	} wave_t;

	typedef logic signed [DATA_WIDTH-1:0] sample_t;
	typedef logic signed [INT_BITS-1:0]   amp_t;

	// One phase step, tagged with the waveform that was selected when it issued.
	typedef struct packed {
		logic                valid;
		wave_t               wave;
		logic [LUT_ADDR-1:0] addr;
	} phase_req_t;

	// One shaped sample on its way to the amplitude multiplier.
	typedef struct packed {
		logic    valid;
		sample_t sample;
	} wave_sample_t;

endpackage

/* hdl/funct_generator.sv */
`timescale 1ns/1ns

module funct_generator
	import funct_gen_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    en_low_i,
	input  logic    enh_conf_i,
	input  amp_t    amp_i,
	input  wave_t   sel_i,
	output sample_t data_o,
	output logic    wr_en_o
);

	logic         clear;
	logic         advance;
	logic         load_amp;
	phase_req_t   phase_req;
	wave_sample_t wave_sample;

	// The controller turns the two level inputs into per-state strobes.
	gen_fsm u_gen_fsm (
		.clk        (clk),
		.rst        (rst),
		.en_low_i   (en_low_i),
		.enh_conf_i (enh_conf_i),
		.clear_o    (clear),
		.advance_o  (advance),
		.load_amp_o (load_amp)
	);

	// Phase steps issue here and the pipeline starts.
	phase_counter u_phase_counter (
		.clk       (clk),
		.rst       (rst),
		.clear_i   (clear),
		.advance_i (advance),
		.sel_i     (sel_i),
		.req_o     (phase_req)
	);

	// First stage is the table lookup and shaping.
	wave_lut u_wave_lut (
		.clk      (clk),
		.rst      (rst),
		.req_i    (phase_req),
		.sample_o (wave_sample)
	);

	// Second stage is the gain and the output register.
	amp_scaler u_amp_scaler (
		.clk        (clk),
		.rst        (rst),
		.load_amp_i (load_amp),
		.amp_i      (amp_i),
		.sample_i   (wave_sample),
		.data_o     (data_o),
		.wr_en_o    (wr_en_o)
	);

endmodule

/* hdl/gen_fsm.sv */
`timescale 1ns/1ns

module gen_fsm
	import funct_gen_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic en_low_i,
	input  logic enh_conf_i,
	output logic clear_o,
	output logic advance_o,
	output logic load_amp_o
);

	state_t state_q;
	state_t state_d;

	// The configure request wins over everything else in every state.
	// The active low enable then decides between running and resting.
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (enh_conf_i) begin
					state_d = CONFI;
				end else if (!en_low_i) begin
					state_d = GEN;
				end
			end
			CONFI: begin
				if (enh_conf_i) begin
					state_d = CONFI;
				end else if (!en_low_i) begin
					state_d = GEN;
				end else begin
					state_d = IDLE;
				end
			end
			GEN: begin
				if (enh_conf_i) begin
					state_d = CONFI;
				end else if (en_low_i) begin
					state_d = IDLE;
				end
			end
			// The spare code falls back to the rest state.
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// The strobes are plain decodes of the registered state.
	// The phase is held at zero whenever the generator is not running.
	assign clear_o    = (state_q == IDLE) || (state_q == CONFI);
	assign advance_o  = (state_q == GEN);
	assign load_amp_o = (state_q == CONFI);

endmodule

/* hdl/phase_counter.sv */
`timescale 1ns/1ns

module phase_counter
	import funct_gen_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       clear_i,
	input  logic       advance_i,
	input  wave_t      sel_i,
	output phase_req_t req_o
);

	logic [LUT_ADDR-1:0] addr_q;
	phase_req_t          req_q;

	// The address steps once per running cycle.
	// It wraps after the last entry on its own because the depth is a power of two.
	always_ff @(posedge clk) begin
		if (rst || clear_i) begin
			addr_q <= '0;
		end else if (advance_i) begin
			addr_q <= addr_q + 1'b1;
		end
	end

	// One request issues per running cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			req_q.valid <= 1'b0;
		end else begin
			req_q.valid <= advance_i;
		end
	end

	// The select is captured with the address, so a later change of sel_i
	// cannot reach a step that has already issued.
	always_ff @(posedge clk) begin
		if (advance_i) begin
			req_q.wave <= sel_i;
			req_q.addr <= addr_q;
		end
	end

	assign req_o = req_q;

endmodule

/* hdl/wave_lut.sv */
`timescale 1ns/1ns

module wave_lut
	import funct_gen_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  phase_req_t   req_i,
	output wave_sample_t sample_o
);

	sample_t sine_rom [LUT_DEPTH];

	logic [LUT_ADDR-1:0] cos_addr;
	logic                upper_half;
	logic [LUT_ADDR-2:0] tri_fold;
	sample_t             sine_val;
	sample_t             cos_val;
	sample_t             tri_val;
	sample_t             square_val;
	sample_t             wave_val;
	wave_sample_t        sample_q;

	// The table holds one full period of the sine.
	initial begin
		$readmemh(SINE_FILE, sine_rom);
	end

	// Cosine leads sine by a quarter period.
	// The sum wraps in the address width because the depth is a power of two.
	assign cos_addr = LUT_ADDR'(req_i.addr + QUARTER_OFFSET);

	assign sine_val = sine_rom[req_i.addr];
	assign cos_val  = sine_rom[cos_addr];

	// The top address bit tells the rising half from the falling half.
	assign upper_half = req_i.addr[LUT_ADDR-1];

	// Folding the upper half back gives a ramp that climbs and then descends.
	assign tri_fold = upper_half ? (LUT_ADDR-1)'(LUT_DEPTH - 1 - int'(req_i.addr))
	                             : req_i.addr[LUT_ADDR-2:0];

	// The ramp starts at minus one.
	assign tri_val = sample_t'(int'(tri_fold) * TRI_STEP - FULL_SCALE);

	// Square is plus one for the first half period and minus one for the second.
	assign square_val = upper_half ? sample_t'(-FULL_SCALE) : sample_t'(FULL_SCALE);

	always_comb begin
		case (req_i.wave)
			SINE:     wave_val = sine_val;
			COSINE:   wave_val = cos_val;
			TRIANGLE: wave_val = tri_val;
			SQUARE:   wave_val = square_val;
			default:  wave_val = sine_val;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sample_q.valid <= 1'b0;
		end else begin
			sample_q.valid <= req_i.valid;
		end
	end

	// The sample only moves when a request arrives.
	always_ff @(posedge clk) begin
		if (req_i.valid) begin
			sample_q.sample <= wave_val;
		end
	end

	assign sample_o = sample_q;

endmodule

/* sine_table.hex */
// One period of sin(2*pi*n/32) as signed Q4.12, one 16-bit hex word per line, n = 0 to 31.
0000
031F
061F
08E4
0B50
0D4E
0EC8
0FB1
1000
0FB1
0EC8
0D4E
0B50
08E4
061F
031F
0000
FCE1
F9E1
F71C
F4B0
F2B2
F138
F04F
F000
F04F
F138
F2B2
F4B0
F71C
F9E1
FCE1

/* testbench/tb_funct_generator.sv */
`timescale 1ns/1ns

module tb_funct_generator
	import funct_gen_pkg::*;
();

	localparam int          TIMEOUT_CYCLES = 1200;
	localparam logic [31:0] SEED           = 32'h75297ec9;

	logic    clk;
	logic    rst;
	logic    en_low;
	logic    enh_conf;
	amp_t    amp_drv;
	wave_t   sel_drv;
	sample_t dut_data;
	logic    dut_wr_en;

	// Reference model state, updated on the same edges as the DUT.
	sample_t     sine_tab [LUT_DEPTH];
	state_t      m_state;
	int          m_addr;
	logic        m_req_valid;
	wave_t       m_req_wave;
	int          m_req_addr;
	logic        m_smp_valid;
	sample_t     m_smp;
	sample_t     m_amp;
	sample_t     exp_q [$];
	sample_t     expected;
	logic [31:0] rand_state;
	int          cycle_count;

	funct_generator u_funct_generator (
		.clk        (clk),
		.rst        (rst),
		.en_low_i   (en_low),
		.enh_conf_i (enh_conf),
		.amp_i      (amp_drv),
		.sel_i      (sel_drv),
		.data_o     (dut_data),
		.wr_en_o    (dut_wr_en)
	);

	always #10 clk = ~clk;

	initial begin
		$readmemh("sine_table.hex", sine_tab);
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw_random(output logic [31:0] r);
		rand_state = lcg_next(rand_state);
		r = rand_state;
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "Stopping at the first error.");
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	// Every state gives configure priority, then follows the active-low enable.
	function automatic state_t next_state(input logic en_low_lvl, input logic conf_lvl);
		if (conf_lvl) begin
			return CONFI;
		end
		return en_low_lvl ? IDLE : GEN;
	endfunction

	// Waveform shaping straight from the table and the fixed-point rules.
	function automatic sample_t shape_sample(input wave_t w, input int addr);
		int fold;
		int val;
		fold = (addr < LUT_DEPTH / 2) ? addr : LUT_DEPTH - 1 - addr;
		case (w)
			SINE:     val = sine_tab[addr];
			COSINE:   val = sine_tab[(addr + QUARTER_OFFSET) % LUT_DEPTH];
			TRIANGLE: val = fold * TRI_STEP - FULL_SCALE;
			default:  val = (addr < LUT_DEPTH / 2) ? FULL_SCALE : -FULL_SCALE;
		endcase
		return sample_t'(val);
	endfunction

	// Q4.12 times Q4.12, back to Q4.12 with the top bits dropped.
	function automatic sample_t scale_sample(input sample_t s, input sample_t gain);
		int prod;
		prod = int'(s) * int'(gain);
		return sample_t'(prod >>> FRAC_BITS);
	endfunction

	// The model runs back to front so each stage sees the value from before the edge.
	// The output check comes last and pops the sample pushed one edge earlier.
	always @(posedge clk) begin
		if (rst) begin
			m_state     = IDLE;
			m_addr      = 0;
			m_req_valid = 1'b0;
			m_smp_valid = 1'b0;
			m_amp       = sample_t'(FULL_SCALE);
			exp_q.delete();
		end else begin
			if (m_smp_valid) begin
				exp_q.push_back(scale_sample(m_smp, m_amp));
			end
			if (m_req_valid) begin
				m_smp = shape_sample(m_req_wave, m_req_addr);
			end
			m_smp_valid = m_req_valid;
			if (m_state == CONFI) begin
				m_amp = sample_t'(int'(amp_drv) * FULL_SCALE);
			end
			m_req_valid = (m_state == GEN);
			if (m_state == GEN) begin
				m_req_wave = sel_drv;
				m_req_addr = m_addr;
				m_addr     = (m_addr + 1) % LUT_DEPTH;
			end else begin
				m_addr = 0;
			end
			m_state = next_state(en_low, enh_conf);
			if (dut_wr_en) begin
				if (exp_q.size() == 0) begin
					abort_run("The DUT wrote a sample that the reference model never issued.");
				end else begin
					expected = exp_q.pop_front();
					assert (dut_data == expected)
					else abort_run($sformatf("MISMATCH at %0t ns: data_o is %0d, expected %0d",
						$time, dut_data, expected));
				end
			end
		end
	end

	// Reset clears the outputs.
	assert property (@(posedge clk) rst |=> (!dut_wr_en && dut_data == '0))
	else abort_run($sformatf("MISMATCH at %0t ns: outputs not cleared by reset", $time));

	// A request issued in GEN shows up as a write two edges later.
	assert property (@(posedge clk) disable iff (rst) (m_state == GEN) |-> ##3 dut_wr_en)
	else abort_run($sformatf("MISMATCH at %0t ns: wr_en_o low two edges after a request", $time));

	// No request means no write two edges later, so the strobe falls as the pipeline drains.
	assert property (@(posedge clk) disable iff (rst) (m_state != GEN) |-> ##3 !dut_wr_en)
	else abort_run($sformatf("MISMATCH at %0t ns: wr_en_o high without a request", $time));

	// data_o holds between writes.
	assert property (@(posedge clk) disable iff (rst) !dut_wr_en |-> $stable(dut_data))
	else abort_run($sformatf("MISMATCH at %0t ns: data_o changed without wr_en_o", $time));

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("The run timed out after %0d clock cycles.", TIMEOUT_CYCLES));
		end
	end

	initial begin
		logic [31:0] rnd;
		rand_state  = SEED;
		cycle_count = 0;
		clk         = 1'b0;
		rst         = 1'b1;
		en_low      = 1'b1;
		enh_conf    = 1'b0;
		amp_drv     = '0;
		sel_drv     = SINE;
		wait_cycles(2);
		rst = 1'b0;
		// Rest in IDLE, then one SINE period at the reset gain of one.
		wait_cycles(10);
		en_low = 1'b0;
		wait_cycles(LUT_DEPTH);
		en_low = 1'b1;
		wait_cycles(4);
		// Each segment starts on a fixed shape and switches to a random one midway.
		en_low = 1'b0;
		for (int seg = 0; seg < 9; seg++) begin
			sel_drv = wave_t'(1 + seg % 3);
			wait_cycles(24);
			draw_random(rnd);
			sel_drv = wave_t'(rnd[17:16]);
			wait_cycles(16);
		end
		// Odd rounds enter CONFI from GEN with samples in flight and use negative gains.
		for (int round = 0; round < 6; round++) begin
			draw_random(rnd);
			amp_drv  = amp_t'({round[0], rnd[18:16]});
			enh_conf = 1'b1;
			wait_cycles(2);
			enh_conf = 1'b0;
			en_low   = 1'b0;
			sel_drv  = wave_t'(rnd[21:20]);
			wait_cycles(3);
			amp_drv = amp_t'(rnd[27:24]);
			wait_cycles(27);
			if (round[0]) begin
				en_low = 1'b1;
				wait_cycles(3);
			end
		end
		// Each return to GEN restarts the phase at zero.
		for (int k = 0; k < 3; k++) begin
			en_low = 1'b1;
			wait_cycles(4);
			en_low  = 1'b0;
			sel_drv = SINE;
			wait_cycles(20);
		end
		en_low = 1'b1;
		wait_cycles(6);
		if (exp_q.size() != 0) begin
			abort_run("Expected samples never appeared on the output.");
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule
